// File: rtl/uart_frame_pkg.sv
`default_nettype none

/* UART frame types
   Character-level records passed between the serial modules, the FIFOs
   and the system-side streams */

package uart_frame_pkg;

  localparam int N_DATA_BITS = 8;  // data bits per frame, no parity

  // one character for the transmitter
  typedef logic [N_DATA_BITS-1:0] tx_byte_t;

  // one received record, brk set means line break and data is zero
  typedef struct packed {
    logic                   brk;
    logic [N_DATA_BITS-1:0] data;
  } rx_char_t;

endpackage

`default_nettype wire

// File: rtl/uart_timing_pkg.sv
`default_nettype none

/* UART line timing
   Line levels and bit-timer values derived from clock and baud frequency */

package uart_timing_pkg;

  localparam logic IDLE_LEVEL = 1'b1;  // idle line and stop bit

  // clocks per bit
  function automatic int bit_period(input int clk_freq, input int bit_freq);
    return clk_freq / bit_freq;
  endfunction

  // timer compare value for the middle of a bit
  function automatic int half_bit_time(input int clk_freq, input int bit_freq);
    int full_bit_time;
    full_bit_time = bit_period(clk_freq, bit_freq) - 1;
    return full_bit_time / 2;
  endfunction

endpackage

`default_nettype wire

// File: rtl/serial_rx.sv
`timescale 1ns/1ps
`default_nettype none

/* Serial receiver
   Restarts its bit timer on every line edge, ignores short glitches and
   reports a line held low through a whole frame as a break record */

module serial_rx #(
  parameter int CLK_FREQ = 48_000_000,  // system clock in Hz
  parameter int BIT_FREQ = 115_200      // baud rate
) (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic                rx,         // async serial line
  output uart_frame_pkg::rx_char_t rec,
  output logic                     rec_valid,
  input  wire logic                rec_ready
);

  import uart_frame_pkg::*;
  import uart_timing_pkg::*;

  localparam int BIT_PERIOD = bit_period(CLK_FREQ, BIT_FREQ);
  localparam int N_TIMER    = $clog2(BIT_PERIOD);
  localparam int N_CNT      = $clog2(N_DATA_BITS + 1);
  localparam logic [N_TIMER-1:0] FULL_BIT = N_TIMER'(BIT_PERIOD - 1);
  localparam logic [N_TIMER-1:0] HALF_BIT = N_TIMER'(half_bit_time(CLK_FREQ, BIT_FREQ));
  localparam logic [N_CNT-1:0]   STOP_CNT = N_CNT'(N_DATA_BITS);

  // in the four data states the lsb tracks the line level
  typedef enum logic [2:0] {
    S_ZERO  = 3'b000,
    S_POS   = 3'b001,
    S_NEG   = 3'b010,
    S_ONE   = 3'b011,
    S_START = 3'b100,
    S_STOP  = 3'b101,
    S_BREAK = 3'b110,
    S_IDLE  = 3'b111
  } state_t;

  state_t                 state;
  state_t                 smp_next;
  logic [2:0]             sync;
  logic                   in;
  logic [N_TIMER-1:0]     timer;
  logic [N_CNT-1:0]       cnt;
  logic [N_DATA_BITS-1:0] shift;
  logic                   steady;
  logic                   start_ok;
  logic                   smp_take;
  logic                   is_stop;
  logic                   stop_good;
  logic                   brk_new;
  logic                   new_rec;

  assign in       = sync[2];  // synchronized line
  assign steady   = (in == state[0]);  // no edge since last restart
  assign start_ok = (state == S_START) && !in && (timer >= HALF_BIT);
  assign is_stop  = (cnt == STOP_CNT);

  always_comb
  begin
    case (state)
      S_ZERO, S_ONE: smp_take = steady && (timer >= FULL_BIT);  // full steady bit
      S_POS, S_NEG:  smp_take = steady && (timer >= HALF_BIT);  // half bit after edge
      default:       smp_take = 1'b0;
    endcase
    if (is_stop)
      smp_next = state[0] ? S_STOP : S_BREAK;
    else
      smp_next = state[0] ? S_ONE : S_ZERO;
  end

  assign stop_good = smp_take && is_stop && state[0];
  // nine zero samples in a row, anything else with a low stop bit is a framing error
  assign brk_new   = smp_take && is_stop && !state[0] && (shift == '0);
  assign new_rec   = stop_good || brk_new;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync      <= {3{IDLE_LEVEL}};
      state     <= S_IDLE;
      timer     <= '0;
      cnt       <= '0;
      rec_valid <= 1'b0;
    end
    else
    begin
      sync <= {sync[1:0], rx};
      case (state)
        S_IDLE:
          if (!in)
          begin
            timer <= '0;
            state <= S_START;
          end
        S_START:
          if (in)
            state <= S_IDLE;  // glitch on idle line
          else if (!start_ok)
            timer <= timer + 1'b1;
          else
          begin
            timer <= '0;
            cnt   <= '0;
            state <= S_ZERO;
          end
        S_ZERO, S_ONE, S_POS, S_NEG:
          if (smp_take)
          begin
            timer <= '0;
            if (!is_stop)
              cnt <= cnt + 1'b1;
            state <= smp_next;
          end
          else if (steady)
            timer <= timer + 1'b1;
          else if (state == S_ZERO || state == S_ONE)
          begin
            timer <= '0;  // re-sync on edge
            state <= state[0] ? S_NEG : S_POS;
          end
          else
          begin
            timer <= timer + HALF_BIT;  // edge was a glitch
            state <= state[0] ? S_ZERO : S_ONE;
          end
        S_STOP:
          state <= S_IDLE;  // single cycle
        S_BREAK:
          if (!in)
            timer <= '0;
          else if (timer < HALF_BIT)
            timer <= timer + 1'b1;
          else
            state <= S_IDLE;  // line back high for half a bit
        default:
          state <= S_BREAK;
      endcase

      if (new_rec)
        rec_valid <= 1'b1;
      else if (rec_ready || start_ok)
        rec_valid <= 1'b0;  // taken, or lost once the next frame starts
    end
  end

  always_ff @(posedge clk)
  begin
    if (smp_take && !is_stop)
      shift <= {state[0], shift[N_DATA_BITS-1:1]};  // lsb first
    if (stop_good)
      rec <= '{brk: 1'b0, data: shift};
    else if (brk_new)
      rec <= '{brk: 1'b1, data: '0};
  end

endmodule

`default_nettype wire

// File: rtl/serial_tx.sv
`timescale 1ns/1ps
`default_nettype none

/* Serial transmitter
   Takes bytes from a stream and shifts them out as 8N1 frames */

module serial_tx #(
  parameter int CLK_FREQ = 48_000_000,  // system clock in Hz
  parameter int BIT_FREQ = 115_200      // baud rate
) (
  input  wire logic                     clk,
  input  wire logic                     arst_n,
  input  wire uart_frame_pkg::tx_byte_t byte_in,
  input  wire logic                     byte_valid,
  output logic                          byte_ready,
  output logic                          tx
);

  import uart_frame_pkg::*;
  import uart_timing_pkg::*;

  localparam int BIT_PERIOD = bit_period(CLK_FREQ, BIT_FREQ);
  localparam int N_TIMER    = $clog2(BIT_PERIOD);
  localparam int FRAME_BITS = N_DATA_BITS + 2;  // start, data, stop
  localparam int N_CNT      = $clog2(FRAME_BITS + 1);
  localparam logic [N_TIMER-1:0] FULL_BIT = N_TIMER'(BIT_PERIOD - 1);
  localparam logic [N_CNT-1:0]   LAST_BIT = N_CNT'(FRAME_BITS - 1);

  logic [FRAME_BITS-1:0] frame;  // bit 0 is on the line
  logic [N_TIMER-1:0]    timer;
  logic [N_CNT-1:0]      cnt;
  logic                  busy;
  logic                  take;

  assign byte_ready = !busy;
  assign take       = byte_valid && !busy;
  assign tx         = frame[0];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      frame <= {FRAME_BITS{IDLE_LEVEL}};
      timer <= '0;
      cnt   <= '0;
      busy  <= 1'b0;
    end
    else if (take)
    begin
      frame <= {IDLE_LEVEL, byte_in, ~IDLE_LEVEL};  // stop, data, start
      timer <= '0;
      cnt   <= '0;
      busy  <= 1'b1;
    end
    else if (busy)
    begin
      if (timer != FULL_BIT)
        timer <= timer + 1'b1;
      else
      begin
        timer <= '0;
        frame <= {IDLE_LEVEL, frame[FRAME_BITS-1:1]};  // refill with idle level
        cnt   <= cnt + 1'b1;
        if (cnt == LAST_BIT)
          busy <= 1'b0;  // stop bit done
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/char_fifo.sv
`timescale 1ns/1ps
`default_nettype none

/* Character FIFO
   Synchronous circular buffer between two valid/ready streams */

module char_fifo #(
  parameter type payload_t  = logic [7:0],
  parameter int  FIFO_DEPTH = 4
) (
  input  wire logic     clk,
  input  wire logic     arst_n,
  input  wire payload_t in_data,
  input  wire logic     in_valid,
  output logic          in_ready,
  output payload_t      out_data,
  output logic          out_valid,
  input  wire logic     out_ready
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  payload_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != FULL_CNT);
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];  // head of queue
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or push and pop together
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_core.sv
`timescale 1ns/1ps
`default_nettype none

/* UART core
   Receiver and transmitter with one character FIFO per direction,
   facing the system through valid/ready streams */

module uart_core #(
  parameter int CLK_FREQ   = 48_000_000,  // system clock in Hz
  parameter int BIT_FREQ   = 115_200,     // baud rate
  parameter int FIFO_DEPTH = 4            // records per FIFO
) (
  input  wire logic                     clk,
  input  wire logic                     arst_n,
  input  wire logic                     rx,
  output logic                          tx,
  input  wire uart_frame_pkg::tx_byte_t tx_data,
  input  wire logic                     tx_valid,
  output logic                          tx_ready,
  output uart_frame_pkg::rx_char_t      rx_char,
  output logic                          rx_valid,
  input  wire logic                     rx_ready
);

  import uart_frame_pkg::*;

  rx_char_t rec;            // receiver to rx_fifo
  logic     rec_valid;
  logic     rec_ready;
  tx_byte_t tx_byte;        // tx_fifo to transmitter
  logic     tx_byte_valid;
  logic     tx_byte_ready;

  serial_rx #(.CLK_FREQ(CLK_FREQ), .BIT_FREQ(BIT_FREQ)) i_serial_rx (
    .clk(clk), .arst_n(arst_n), .rx(rx),
    .rec(rec), .rec_valid(rec_valid), .rec_ready(rec_ready)
  );

  char_fifo #(.payload_t(rx_char_t), .FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
    .clk(clk), .arst_n(arst_n),
    .in_data(rec), .in_valid(rec_valid), .in_ready(rec_ready),
    .out_data(rx_char), .out_valid(rx_valid), .out_ready(rx_ready)
  );

  char_fifo #(.payload_t(tx_byte_t), .FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
    .clk(clk), .arst_n(arst_n),
    .in_data(tx_data), .in_valid(tx_valid), .in_ready(tx_ready),
    .out_data(tx_byte), .out_valid(tx_byte_valid), .out_ready(tx_byte_ready)
  );

  serial_tx #(.CLK_FREQ(CLK_FREQ), .BIT_FREQ(BIT_FREQ)) i_serial_tx (
    .clk(clk), .arst_n(arst_n),
    .byte_in(tx_byte), .byte_valid(tx_byte_valid), .byte_ready(tx_byte_ready),
    .tx(tx)
  );

endmodule

`default_nettype wire

// File: tb/uart_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

/* UART core testbench
   Loops tx back to rx and runs a command script of sends, breaks,
   glitches and expected receive records */

module uart_core_tb;

  import uart_frame_pkg::*;
  import uart_timing_pkg::*;

  localparam int CLK_FREQ    = 250_000_000;
  localparam int BIT_FREQ    = 15_625_000;
  localparam int FIFO_DEPTH  = 4;
  localparam int BIT_CLKS    = bit_period(CLK_FREQ, BIT_FREQ);
  localparam int TIMEOUT     = 40 * BIT_CLKS;  // per valid/ready wait
  localparam int DRAIN_LIMIT = (FIFO_DEPTH + 2) * 10 * BIT_CLKS;
  localparam int FRAME_SKIP  = (N_DATA_BITS + 1) * BIT_CLKS + BIT_CLKS / 2;  // to mid stop bit
  localparam int GLITCH_CLKS = half_bit_time(CLK_FREQ, BIT_FREQ) - 2;
  localparam int BREAK_BITS  = 12;

  logic     clk = 1'b0;
  logic     arst_n;
  logic     line;         // serial line into the DUT
  logic     loopback;
  logic     drive_level;
  logic     tx;
  tx_byte_t tx_data;
  logic     tx_valid;
  logic     tx_ready;
  rx_char_t rx_char;
  logic     rx_valid;
  logic     rx_ready;
  int       accepted;     // bytes taken by the transmit FIFO
  int       started;      // frames seen on tx
  int       frame_gap;
  int       seed;

  assign line = loopback ? tx : drive_level;

  uart_core #(.CLK_FREQ(CLK_FREQ), .BIT_FREQ(BIT_FREQ), .FIFO_DEPTH(FIFO_DEPTH)) i_uart_core (
    .clk(clk), .arst_n(arst_n), .rx(line), .tx(tx),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
    .rx_char(rx_char), .rx_valid(rx_valid), .rx_ready(rx_ready)
  );

  always #2 clk = ~clk;

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic compare_char(input string name, input rx_char_t exp, input rx_char_t act);
    if (act !== exp)
    begin
      $display("FAIL at %0t: %s expected brk=%0b data=%h, got brk=%0b data=%h",
               $time, name, exp.brk, exp.data, act.brk, act.data);
      abort_run();
    end
  endtask

  task automatic compare_line(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAIL at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic require_arg(input int code);
    if (code != 1)
    begin
      $display("missing or malformed argument in the stimulus file");
      abort_run();
    end
  endtask

  function automatic rx_char_t char_record(input logic brk, input tx_byte_t data);
    rx_char_t r;
    r.brk  = brk;
    r.data = data;
    return r;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // counts frame starts on tx and checks tx_ready against the transmit FIFO fill
  always @(negedge clk)
  begin
    if (arst_n)
    begin
      if (frame_gap > 0)
        frame_gap = frame_gap - 1;
      else if (!tx)
      begin
        started   = started + 1;
        frame_gap = FRAME_SKIP;
      end
      compare_line("tx_ready", (accepted - started) < FIFO_DEPTH, tx_ready);
    end
  end

  task automatic send_byte(input tx_byte_t b);
    int n;
    n        = 0;
    tx_data  = b;
    tx_valid = 1'b1;
    while (!tx_ready)
    begin
      step();
      n++;
      if (n > TIMEOUT)
      begin
        $display("timeout: tx_ready never rose for a byte to send");
        abort_run();
      end
    end
    step();  // transfer edge
    accepted++;
    tx_valid = 1'b0;
  endtask

  task automatic take_record(output rx_char_t rec);
    int n;
    n = 0;
    while (!rx_valid)
    begin
      step();
      n++;
      if (n > TIMEOUT)
      begin
        $display("timeout: rx_valid never rose for an expected record");
        abort_run();
      end
    end
    rec      = rx_char;
    rx_ready = 1'b1;
    step();
    rx_ready = 1'b0;
  endtask

  task automatic wait_line_quiet();
    int n;
    n = 0;
    while (accepted != started || frame_gap != 0)
    begin
      step();
      n++;
      if (n > DRAIN_LIMIT)
      begin
        $display("timeout: transmitter did not finish its queued frames");
        abort_run();
      end
    end
    repeat (BIT_CLKS) step();  // receiver checks the stop bit
  endtask

  task automatic check_quiet(input int bits);
    repeat (bits * BIT_CLKS)
    begin
      step();
      compare_line("tx", IDLE_LEVEL, tx);
      compare_line("rx_valid", 1'b0, rx_valid);
    end
  endtask

  task automatic force_line(input logic level, input int clks);
    loopback    = 1'b0;
    drive_level = level;
    repeat (clks) step();
  endtask

  initial
  begin : run_script
    int               fd;
    int               code;
    int               n;
    int               i;
    logic [8*16-1:0]  cmd;
    logic [8*128-1:0] rest;
    tx_byte_t         b;
    tx_byte_t         sent [$];
    rx_char_t         got;
    arst_n      = 1'b0;
    loopback    = 1'b1;
    drive_level = IDLE_LEVEL;
    tx_data     = '0;
    tx_valid    = 1'b0;
    rx_ready    = 1'b0;
    accepted    = 0;
    started     = 0;
    frame_gap   = 0;
    seed        = 32'hba3c52dc;
    fd = $fopen("tb/uart_core_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the stimulus file tb/uart_core_stimulus.txt");
      abort_run();
    end
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    while ($fscanf(fd, "%s", cmd) == 1)
    begin
      case (cmd)
        "#":
          code = $fgets(rest, fd);  // comment line
        "quiet":
        begin
          code = $fscanf(fd, "%d", n);
          require_arg(code);
          check_quiet(n);
        end
        "send":
        begin
          code = $fscanf(fd, "%h", b);
          require_arg(code);
          send_byte(b);
        end
        "hold":
        begin
          code = $fscanf(fd, "%d", n);
          require_arg(code);
          for (i = 0; i < n; i++)
          begin
            code = $fscanf(fd, "%h", b);
            require_arg(code);
            send_byte(b);
          end
          wait_line_quiet();  // all records now sit in the receive FIFO
        end
        "random":
        begin
          code = $fscanf(fd, "%d", n);
          require_arg(code);
          for (i = 0; i < n; i++)
          begin
            b = tx_byte_t'($random(seed));
            sent.push_back(b);
            send_byte(b);
          end
          while (sent.size() > 0)
          begin
            b = sent.pop_front();
            take_record(got);
            compare_char("rx_char", char_record(1'b0, b), got);
          end
        end
        "break":
        begin
          wait_line_quiet();
          force_line(1'b0, BREAK_BITS * BIT_CLKS);
          force_line(1'b1, 2 * BIT_CLKS);  // lets the receiver leave break
          loopback = 1'b1;
        end
        "glitch":
        begin
          wait_line_quiet();
          force_line(1'b0, GLITCH_CLKS);
          loopback = 1'b1;
          check_quiet(2 * (N_DATA_BITS + 2));  // longer than any false frame
        end
        "expect":
        begin
          code = $fscanf(fd, "%h", b);
          require_arg(code);
          take_record(got);
          compare_char("rx_char", char_record(1'b0, b), got);
        end
        "expect_break":
        begin
          take_record(got);
          compare_char("rx_char", char_record(1'b1, '0), got);
        end
        default:
        begin
          $display("unknown command in the stimulus file");
          abort_run();
        end
      endcase
    end
    $fclose(fd);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
rtl/uart_frame_pkg.sv
rtl/uart_timing_pkg.sv
rtl/serial_rx.sv
rtl/serial_tx.sv
rtl/char_fifo.sv
rtl/uart_core.sv
tb/uart_core_tb.sv

// File: tb/uart_core_stimulus.txt
# command  arguments (counts decimal, bytes hex)
# quiet n | send hh | hold n hh.. | random n | break | glitch | expect hh | expect_break
quiet 20
send 55
expect 55
send 00
send ff
send a3
expect 00
expect ff
expect a3
hold 4 3c a5 0f f0
expect 3c
expect a5
expect 0f
expect f0
break
expect_break
send 5a
expect 5a
glitch
send 96
expect 96
random 6
quiet 4
